// ==== sim.f ====
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_hazard.sv
design/rv_core.sv
dv/rv_core_asserts.sv
dv/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) -f sim.f --top-module $(TOP) -Mdir $(BUILD_DIR) -o sim
	$(BUILD_DIR)/sim | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/rv_core_tb.sv ====
`default_nettype none

`include "rv_core_defines.svh"

module rv_core_tb
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
();

  localparam int PROG_LEN  = 200;
  localparam int RST_CYC   = 16;
  localparam int CYC_LIMIT = 3 * PROG_LEN + RST_CYC + 40;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] instr;
  logic [31:0] data_mem;
  logic [31:0] pc_addr;
  mem_req_t    dmem;
  wb_trace_t   wb;

  logic [31:0] imem [256];
  logic [31:0] dmem_arr [256];
  logic [31:0] model_mem [256];
  logic [31:0] model_regs [`RV_NREGS];
  logic [31:0] lfsr_state = 32'd68519;

  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  logic [31:0] st_addr [$];
  logic [31:0] st_data [$];

  int wb_errors = 0;
  int store_errors = 0;
  int other_errors = 0;
  int cycles = 0;
  bit started = 0;

  rv_core u_rv_core (
    .clk(clk), .rst(rst), .instr(instr), .data_mem(data_mem),
    .pc_addr(pc_addr), .dmem(dmem), .wb(wb)
  );

  always #10 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rnd(input int nbits);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < nbits; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [4:0] pick_rd();
    logic [4:0] r;
    r = 5'(rnd(3));
    return (r == 0) ? 5'd7 : r;
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] im, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] im, input logic [4:0] rd);
    return {im[20], im[10:1], im[11], im[19:12], rd, OPC_JAL};
  endfunction

  // Forward targets two to five words ahead
  function automatic logic [31:0] gen_instr(input int idx);
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [2:0]  f3;
    logic [11:0] im;
    logic [6:0]  f7;
    kind = 4'(rnd(4));
    rd = pick_rd();
    ra = 5'(rnd(3));
    rb = 5'(rnd(3));
    f3 = 3'(rnd(3));
    im = 12'(rnd(12));
    if (idx >= PROG_LEN - 10 && kind >= 12 && kind <= 14) kind = 4'd5;
    case (kind)
      0, 1, 2, 3, 4: begin
        f7 = ((f3 == 0 || f3 == 5) && rnd(1) == 1) ? 7'h20 : 7'h00;
        if (rnd(2) == 0) begin
          f7 = F7_MULDIV;
          f3 = 3'd0;
        end
        return {f7, rb, ra, f3, rd, OPC_OP};
      end
      5, 6, 7: begin
        if (f3 == 1) im = {7'd0, im[4:0]};
        if (f3 == 5) im = {1'b0, im[10], 5'd0, im[4:0]};
        return {im, ra, f3, rd, OPC_OP_IMM};
      end
      8:  return {20'(rnd(20)), rd, OPC_LUI};
      9:  return {20'(rnd(20)), rd, OPC_AUIPC};
      11: begin
        im = 12'(rnd(4) << 2);
        return {im[11:5], rb, 5'd8, 3'b010, im[4:0], OPC_STORE};
      end
      12: begin
        if (f3 == 2 || f3 == 3) f3 = f3 + 3'd2;
        return enc_b(13'(8 + 4 * rnd(2)), rb, ra, f3);
      end
      13: return enc_j(21'(8 + 4 * rnd(2)), rd);
      14: return {12'(4 * idx + 8 + 4 * rnd(2)), 5'd0, 3'd0, rd, OPC_JALR};
      default: return {12'(rnd(4) << 2), 5'd8, 3'b010, rd, OPC_LOAD};
    endcase
  endfunction

  function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic void set_reg(input logic [4:0] rd, input logic [31:0] v);
    if (rd != 0) begin
      model_regs[rd] = v;
      exp_rd.push_back(rd);
      exp_data.push_back(v);
    end
  endfunction

  task automatic run_model();
    logic [31:0] pc;
    logic [31:0] nxt;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] si;
    logic        c;
    rv_instr_u   u;
    pc = `RV_RESET_PC;
    for (int n = 0; n < 4 * PROG_LEN; n++) begin
      u = imem[pc[9:2]];
      if (u == enc_j(21'd0, 5'd0)) break;
      a = model_regs[u.r.rs1];
      b = model_regs[u.r.rs2];
      si = {{20{u.i.imm[11]}}, u.i.imm};
      nxt = pc + 4;
      case (u.r.opcode)
        OPC_OP: set_reg(u.r.rd, u.r.funct7 == F7_MULDIV ? a * b
                                : alu(u.r.funct3, u.r.funct7[5], a, b));
        OPC_OP_IMM: set_reg(u.i.rd, alu(u.i.funct3, u.i.funct3 == 5 && u.i.imm[10], a, si));
        OPC_LUI: set_reg(u.u.rd, {u.u.imm, 12'd0});
        OPC_AUIPC: set_reg(u.u.rd, pc + {u.u.imm, 12'd0});
        OPC_LOAD: set_reg(u.i.rd, model_mem[(a + si) >> 2]);
        OPC_STORE: begin
          si = {{20{u.s.imm_hi[6]}}, u.s.imm_hi, u.s.imm_lo};
          model_mem[(a + si) >> 2] = b;
          st_addr.push_back(a + si);
          st_data.push_back(b);
        end
        OPC_BRANCH: begin
          case (u.b.funct3)
            F3_BEQ:  c = a == b;
            F3_BNE:  c = a != b;
            F3_BLT:  c = $signed(a) < $signed(b);
            F3_BGE:  c = $signed(a) >= $signed(b);
            F3_BLTU: c = a < b;
            default: c = a >= b;
          endcase
          if (c) nxt = pc + {{19{u.b.imm12}}, u.b.imm12, u.b.imm11, u.b.imm10_5,
                             u.b.imm4_1, 1'b0};
        end
        OPC_JAL: begin
          set_reg(u.j.rd, pc + 4);
          nxt = pc + {{11{u.j.imm20}}, u.j.imm20, u.j.imm19_12, u.j.imm11,
                      u.j.imm10_1, 1'b0};
        end
        OPC_JALR: begin
          set_reg(u.i.rd, pc + 4);
          nxt = (a + si) & ~32'd1;
        end
        default: ;
      endcase
      pc = nxt;
    end
  endtask

  // Memory models answer the address seen at each edge
  always @(posedge clk) begin
    instr <= imem[pc_addr[9:2]];
    if (dmem.read) data_mem <= dmem_arr[dmem.addr[9:2]];
    if (dmem.write) dmem_arr[dmem.addr[9:2]] <= dmem.wdata;
  end

  always @(posedge clk) begin
    if (!rst) begin
      cycles++;
      if (!started) begin
        started = 1;
        assert (pc_addr == `RV_RESET_PC) else begin
          other_errors++;
          $display("FAIL t=%0t pc_addr expected %h got %h", $time, `RV_RESET_PC, pc_addr);
        end
      end
      if (wb.valid) begin
        assert (exp_rd.size() != 0 && wb.rd != 0) else begin
          other_errors++;
          $display("Unexpected register write to x%0d at t=%0t", wb.rd, $time);
        end
        if (exp_rd.size() != 0) begin
          assert (wb.rd == exp_rd[0]) else begin
            wb_errors++;
            $display("FAIL t=%0t wb.rd expected %0d got %0d", $time, exp_rd[0], wb.rd);
          end
          assert (wb.data == exp_data[0]) else begin
            wb_errors++;
            $display("FAIL t=%0t wb.data expected %h got %h", $time, exp_data[0], wb.data);
          end
          void'(exp_rd.pop_front());
          void'(exp_data.pop_front());
        end
      end
      if (dmem.write) begin
        assert (st_addr.size() != 0) else begin
          other_errors++;
          $display("Unexpected store to %h at t=%0t", dmem.addr, $time);
        end
        if (st_addr.size() != 0) begin
          assert (dmem.addr == st_addr[0]) else begin
            store_errors++;
            $display("FAIL t=%0t dmem.addr expected %h got %h", $time, st_addr[0], dmem.addr);
          end
          assert (dmem.wdata == st_data[0]) else begin
            store_errors++;
            $display("FAIL t=%0t dmem.wdata expected %h got %h", $time, st_data[0],
                     dmem.wdata);
          end
          void'(st_addr.pop_front());
          void'(st_data.pop_front());
        end
      end
    end
  end

  initial begin
    rst = 1'b1;
    instr = '0;
    data_mem = '0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem_arr[i] = 32'h5a00_0000 ^ (i * 32'h0101_0107);
      model_mem[i] = dmem_arr[i];
    end
    for (int i = 0; i < `RV_NREGS; i++) model_regs[i] = '0;
    // Base register for loads and stores
    imem[0] = {12'h100, 5'd0, 3'd0, 5'd8, OPC_OP_IMM};
    for (int i = 1; i < PROG_LEN - 1; i++) imem[i] = gen_instr(i);
    imem[PROG_LEN - 1] = enc_j(21'd0, 5'd0);
    run_model();
    repeat (RST_CYC) @(posedge clk);
    rst <= 1'b0;
    while ((exp_rd.size() != 0 || st_addr.size() != 0) && cycles < CYC_LIMIT) begin
      @(posedge clk);
    end
    if (exp_rd.size() != 0 || st_addr.size() != 0) begin
      $display("Timeout: %0d register writes and %0d stores never arrived",
               exp_rd.size(), st_addr.size());
      $display("Result: FAILED");
      $finish;
    end else begin
      repeat (10) @(posedge clk);
      $display("Errors: wb %0d, store %0d, other %0d", wb_errors, store_errors, other_errors);
      if (wb_errors + store_errors + other_errors == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== dv/rv_core_asserts.sv ====
`default_nettype none

module rv_core_asserts
  import rv_pipe_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input mem_req_t    dmem,
  input wb_trace_t   wb,
  input logic        taken,
  input logic [31:0] target,
  input logic [31:0] pc_addr,
  input logic        stall
);

  a_mem_excl: assert property (@(posedge clk) disable iff (rst) !(dmem.read && dmem.write))
    else $error("data memory read and write high together");

  a_wb_rd: assert property (@(posedge clk) disable iff (rst) wb.valid |-> wb.rd != 5'd0)
    else $error("retire trace reports x0");

  a_redirect: assert property (@(posedge clk) disable iff (rst)
    taken |=> pc_addr == $past(target))
    else $error("fetch address does not follow the taken target");

  a_stall_once: assert property (@(posedge clk) disable iff (rst) stall |=> !stall)
    else $error("load-use stall lasted two cycles");

endmodule

bind rv_core rv_core_asserts u_rv_core_asserts (
  .clk(clk), .rst(rst), .dmem(dmem), .wb(wb), .taken(taken),
  .target(target), .pc_addr(pc_addr), .stall(stall)
);

`default_nettype wire

// ==== design/rv_core.sv ====
`default_nettype none

`include "rv_core_defines.svh"

module rv_core
  import rv_pipe_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [`RV_XLEN-1:0] instr,
  input  logic [`RV_XLEN-1:0] data_mem,
  output logic [`RV_XLEN-1:0] pc_addr,
  output mem_req_t            dmem,
  output wb_trace_t           wb
);

  logic [`RV_XLEN-1:0] pc;

  // Decode entry for the word now on instr
  logic                id_valid;
  logic [`RV_XLEN-1:0] id_pc;
  logic                id_replay;
  logic [`RV_XLEN-1:0] id_word;
  logic [`RV_XLEN-1:0] id_instr;

  ctrl_t               dec_ctrl;
  logic [4:0]          dec_rs1;
  logic [4:0]          dec_rs2;
  logic [4:0]          dec_rd;
  logic [`RV_XLEN-1:0] dec_imm;
  logic [`RV_XLEN-1:0] rf_rdata1;
  logic [`RV_XLEN-1:0] rf_rdata2;

  id_ex_t              id_ex;
  ex_mem_t             ex_mem;
  mem_wb_t             mem_wb;

  fwd_sel_e            fwd_a;
  fwd_sel_e            fwd_b;
  logic                stall;
  logic                flush;
  logic                taken;
  logic [`RV_XLEN-1:0] target;
  logic [`RV_XLEN-1:0] ex_result;
  logic [`RV_XLEN-1:0] ex_store_data;
  logic [`RV_XLEN-1:0] wb_value;

  assign pc_addr = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else if (taken) begin
      pc <= target;
    end else if (!stall) begin
      pc <= pc + 'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      id_valid <= 1'b0;
    end else if (!stall) begin
      id_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      id_replay <= 1'b0;
    end else begin
      id_replay <= stall;
    end
  end

  // Memory answers the held pc during a stall, so keep the stalled word
  always_ff @(posedge clk) begin
    if (stall) begin
      id_word <= instr;
    end else begin
      id_pc <= pc;
    end
  end

  assign id_instr = id_replay ? id_word : instr;

  rv_decoder u_rv_decoder (
    .instr (id_instr),
    .ctrl  (dec_ctrl),
    .rs1   (dec_rs1),
    .rs2   (dec_rs2),
    .rd    (dec_rd),
    .imm   (dec_imm)
  );

  rv_regfile u_rv_regfile (
    .clk    (clk),
    .rst    (rst),
    .we     (mem_wb.ctrl.reg_write),
    .waddr  (mem_wb.rd),
    .wdata  (wb_value),
    .raddr1 (dec_rs1),
    .raddr2 (dec_rs2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2)
  );

  always_ff @(posedge clk) begin
    if (rst || flush || stall || !id_valid) begin
      id_ex <= '0;
    end else begin
      id_ex <= '{valid: 1'b1, pc: id_pc, ctrl: dec_ctrl, funct3: id_instr[14:12],
                 rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd,
                 rs1_val: rf_rdata1, rs2_val: rf_rdata2, imm: dec_imm};
    end
  end

  rv_execute u_rv_execute (
    .ex         (id_ex),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .mem_result (ex_mem.result),
    .wb_value   (wb_value),
    .result     (ex_result),
    .store_data (ex_store_data),
    .taken      (taken),
    .target     (target)
  );

  rv_hazard u_rv_hazard (
    .ex_rs1   (id_ex.rs1),
    .ex_rs2   (id_ex.rs2),
    .mem_rd   (ex_mem.rd),
    .wb_rd    (mem_wb.rd),
    .mem_ctrl (ex_mem.ctrl),
    .wb_ctrl  (mem_wb.ctrl),
    .id_rs1   (id_valid ? dec_rs1 : 5'd0),
    .id_rs2   (id_valid ? dec_rs2 : 5'd0),
    .ex_rd    (id_ex.rd),
    .ex_load  (id_ex.ctrl.mem_read),
    .taken    (taken),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b),
    .stall    (stall),
    .flush    (flush)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem <= '0;
    end else begin
      ex_mem <= '{valid: id_ex.valid, pc: id_ex.pc, ctrl: id_ex.ctrl, rd: id_ex.rd,
                  result: ex_result, store_data: ex_store_data};
    end
  end

  assign dmem.read  = ex_mem.valid && ex_mem.ctrl.mem_read;
  assign dmem.write = ex_mem.valid && ex_mem.ctrl.mem_write;
  assign dmem.addr  = ex_mem.result;
  assign dmem.wdata = ex_mem.store_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb <= '0;
    end else begin
      mem_wb <= '{valid: ex_mem.valid, pc: ex_mem.pc, ctrl: ex_mem.ctrl, rd: ex_mem.rd,
                  result: ex_mem.result};
    end
  end

  // Load data arrives in this stage
  always_comb begin
    if (mem_wb.ctrl.jump) begin
      wb_value = mem_wb.pc + 'd4;
    end else if (mem_wb.ctrl.mem_read) begin
      wb_value = data_mem;
    end else begin
      wb_value = mem_wb.result;
    end
  end

  assign wb.valid = mem_wb.valid && mem_wb.ctrl.reg_write && mem_wb.rd != '0;
  assign wb.rd    = mem_wb.rd;
  assign wb.data  = wb_value;

endmodule

`default_nettype wire

// ==== design/rv_hazard.sv ====
`default_nettype none

module rv_hazard
  import rv_pipe_pkg::*;
(
  input  logic [4:0] ex_rs1,
  input  logic [4:0] ex_rs2,
  input  logic [4:0] mem_rd,
  input  logic [4:0] wb_rd,
  input  ctrl_t      mem_ctrl,
  input  ctrl_t      wb_ctrl,
  input  logic [4:0] id_rs1,
  input  logic [4:0] id_rs2,
  input  logic [4:0] ex_rd,
  input  logic       ex_load,
  input  logic       taken,
  output fwd_sel_e   fwd_a,
  output fwd_sel_e   fwd_b,
  output logic       stall,
  output logic       flush
);

  logic mem_fwd_ok;
  logic wb_fwd_ok;

  // A load in memory only holds its address
  assign mem_fwd_ok = mem_ctrl.reg_write && !mem_ctrl.mem_read && mem_rd != '0;
  assign wb_fwd_ok  = wb_ctrl.reg_write && wb_rd != '0;

  // Youngest producer wins
  function automatic fwd_sel_e src_for(input logic [4:0] rs);
    if (mem_fwd_ok && mem_rd == rs) begin
      return FWD_MEM;
    end
    if (wb_fwd_ok && wb_rd == rs) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  always_comb begin
    fwd_a = src_for(ex_rs1);
    fwd_b = src_for(ex_rs2);
  end

  assign stall = ex_load && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);
  assign flush = taken;

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
`default_nettype none

`include "rv_core_defines.svh"

module rv_execute
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  id_ex_t              ex,
  input  fwd_sel_e            fwd_a,
  input  fwd_sel_e            fwd_b,
  input  logic [`RV_XLEN-1:0] mem_result,
  input  logic [`RV_XLEN-1:0] wb_value,
  output logic [`RV_XLEN-1:0] result,
  output logic [`RV_XLEN-1:0] store_data,
  output logic                taken,
  output logic [`RV_XLEN-1:0] target
);

  logic [`RV_XLEN-1:0] rs1_fwd;
  logic [`RV_XLEN-1:0] rs2_fwd;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_res;
  logic [`RV_XLEN-1:0] tgt_sum;
  logic                cond;

  function automatic logic [`RV_XLEN-1:0] operand(
    input fwd_sel_e            sel,
    input logic [`RV_XLEN-1:0] rf_val
  );
    case (sel)
      FWD_MEM: return mem_result;
      FWD_WB:  return wb_value;
      default: return rf_val;
    endcase
  endfunction

  always_comb begin
    rs1_fwd = operand(fwd_a, ex.rs1_val);
    rs2_fwd = operand(fwd_b, ex.rs2_val);
  end

  assign op_a       = ex.ctrl.zero_a ? '0 : (ex.ctrl.src_a_pc ? ex.pc : rs1_fwd);
  assign op_b       = ex.ctrl.src_b_imm ? ex.imm : rs2_fwd;
  assign store_data = rs2_fwd;

  always_comb begin
    case (ex.ctrl.alu_op)
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << op_b[4:0];
      ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> op_b[4:0];
      ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      default:  alu_res = op_a + op_b;
    endcase
  end

  // Low half of the product only
  assign result = ex.ctrl.mul ? rs1_fwd * rs2_fwd : alu_res;

  always_comb begin
    case (ex.funct3)
      F3_BEQ:  cond = (rs1_fwd == rs2_fwd);
      F3_BNE:  cond = (rs1_fwd != rs2_fwd);
      F3_BLT:  cond = ($signed(rs1_fwd) < $signed(rs2_fwd));
      F3_BGE:  cond = ($signed(rs1_fwd) >= $signed(rs2_fwd));
      F3_BLTU: cond = (rs1_fwd < rs2_fwd);
      F3_BGEU: cond = (rs1_fwd >= rs2_fwd);
      default: cond = 1'b0;
    endcase
  end

  assign taken   = ex.valid && (ex.ctrl.jump || (ex.ctrl.branch && cond));
  assign tgt_sum = (ex.ctrl.jalr ? rs1_fwd : ex.pc) + ex.imm;
  assign target  = {tgt_sum[`RV_XLEN-1:1], tgt_sum[0] & ~ex.ctrl.jalr};

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
`default_nettype none

`include "rv_core_defines.svh"

module rv_regfile (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         we,
  input  logic [$clog2(`RV_NREGS)-1:0] waddr,
  input  logic [`RV_XLEN-1:0]          wdata,
  input  logic [$clog2(`RV_NREGS)-1:0] raddr1,
  input  logic [$clog2(`RV_NREGS)-1:0] raddr2,
  output logic [`RV_XLEN-1:0]          rdata1,
  output logic [`RV_XLEN-1:0]          rdata2
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Write-first so decode sees the value retiring this cycle
  function automatic logic [`RV_XLEN-1:0] read_port(
    input logic [$clog2(`RV_NREGS)-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end
    if (we && addr == waddr) begin
      return wdata;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rdata1 = read_port(raddr1);
    rdata2 = read_port(raddr2);
  end

endmodule

`default_nettype wire

// ==== design/rv_decoder.sv ====
`default_nettype none

`include "rv_core_defines.svh"

module rv_decoder
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  rv_instr_u           instr,
  output ctrl_t               ctrl,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  output logic [4:0]          rd,
  output logic [`RV_XLEN-1:0] imm
);

  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  assign imm_i = {{(`RV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{(`RV_XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_b = {{(`RV_XLEN-12){instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                  instr.b.imm4_1, 1'b0};
  assign imm_u = {instr.u.imm, 12'b0};
  assign imm_j = {{(`RV_XLEN-20){instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
                  instr.j.imm10_1, 1'b0};

  // Unused source fields stay zero so they never cause a stall
  always_comb begin
    ctrl = '0;
    rs1  = '0;
    rs2  = '0;
    rd   = instr.r.rd;
    imm  = '0;
    case (instr.r.opcode)
      OPC_OP: begin
        rs1            = instr.r.rs1;
        rs2            = instr.r.rs2;
        ctrl.reg_write = 1'b1;
        ctrl.mul       = (instr.r.funct7 == F7_MULDIV);
        ctrl.alu_op    = alu_op_e'({instr.r.funct7[5], instr.r.funct3});
      end
      OPC_OP_IMM: begin
        rs1            = instr.i.rs1;
        imm            = imm_i;
        ctrl.reg_write = 1'b1;
        ctrl.src_b_imm = 1'b1;
        // Bit 30 picks SRAI only
        ctrl.alu_op    = alu_op_e'({instr.i.funct3 == F3_SR && instr.i.imm[10],
                                    instr.i.funct3});
      end
      OPC_LOAD: begin
        rs1            = instr.i.rs1;
        imm            = imm_i;
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.src_b_imm = 1'b1;
      end
      OPC_STORE: begin
        rs1            = instr.s.rs1;
        rs2            = instr.s.rs2;
        imm            = imm_s;
        ctrl.mem_write = 1'b1;
        ctrl.src_b_imm = 1'b1;
      end
      OPC_BRANCH: begin
        rs1         = instr.b.rs1;
        rs2         = instr.b.rs2;
        imm         = imm_b;
        ctrl.branch = 1'b1;
      end
      OPC_LUI: begin
        imm            = imm_u;
        ctrl.reg_write = 1'b1;
        ctrl.zero_a    = 1'b1;
        ctrl.src_b_imm = 1'b1;
      end
      OPC_AUIPC: begin
        imm            = imm_u;
        ctrl.reg_write = 1'b1;
        ctrl.src_a_pc  = 1'b1;
        ctrl.src_b_imm = 1'b1;
      end
      OPC_JAL: begin
        imm            = imm_j;
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
      end
      OPC_JALR: begin
        rs1            = instr.i.rs1;
        imm            = imm_i;
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.jalr      = 1'b1;
      end
      default: begin
        rd = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/rv_pipe_pkg.sv ====
`default_nettype none

`include "rv_core_defines.svh"

package rv_pipe_pkg;

  import rv_isa_pkg::*;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    jump;
    logic    jalr;
    logic    mul;
    alu_op_e alu_op;
    logic    src_a_pc;
    logic    src_b_imm;
    // LUI adds the immediate to zero
    logic    zero_a;
  } ctrl_t;

  typedef enum logic [1:0] {
    FWD_RF  = 2'd0,
    FWD_MEM = 2'd1,
    FWD_WB  = 2'd2
  } fwd_sel_e;

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    ctrl_t               ctrl;
    logic [2:0]          funct3;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] imm;
  } id_ex_t;

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    ctrl_t               ctrl;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] result;
    logic [`RV_XLEN-1:0] store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    ctrl_t               ctrl;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] result;
  } mem_wb_t;

  typedef struct packed {
    logic                read;
    logic                write;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                valid;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] data;
  } wb_trace_t;

endpackage

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } rv_opcode_e;

  // Encoded as {funct7[5], funct3} of the R-type op
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    rv_opcode_e opcode;
  } rv_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    rv_opcode_e  opcode;
  } rv_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    rv_opcode_e opcode;
  } rv_s_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    rv_opcode_e opcode;
  } rv_b_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    rv_opcode_e  opcode;
  } rv_u_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    rv_opcode_e opcode;
  } rv_j_t;

  typedef union packed {
    rv_r_t r;
    rv_i_t i;
    rv_s_t s;
    rv_b_t b;
    rv_u_t u;
    rv_j_t j;
  } rv_instr_u;

endpackage

`default_nettype wire

// ==== design/rv_core_defines.svh ====
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Data and address width
`define RV_XLEN 32

// Architectural registers including x0
`define RV_NREGS 32

`define RV_RESET_PC 32'h0000_0000

`endif
